// ==== axi_isolate.f ====
verilog/axi_iso_pkg.sv
verilog/axi_iso_pending_cnt.sv
verilog/axi_iso_chan_ctrl.sv
verilog/axi_iso_wr_path.sv
verilog/axi_iso_rd_path.sv
verilog/axi_isolate.sv
test/axi_iso_slave_model.sv
test/tb_axi_isolate.sv

// ==== Makefile ====
# Verilator build and run for the AXI isolator testbench

VERILATOR   ?= verilator
TOP         ?= tb_axi_isolate
LOG         ?= sim.log
NUM_PENDING ?= 4
MDIR        ?= obj_dir
FLIST       ?= axi_isolate.f

VFLAGS ?= --binary --timing --assert

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) \
		-GNUM_PENDING=$(NUM_PENDING) -Mdir $(MDIR)

run: compile
	./$(MDIR)/V$(TOP) | tee $(LOG)
	grep -q "All tests passed" $(LOG)

clean:
	rm -rf $(MDIR) $(LOG)

// ==== test/tb_axi_isolate.sv ====
// Testbench for the AXI isolator with clock, reset, stimulus, scoreboard and assertions
module tb_axi_isolate import axi_iso_pkg::*; #(
  parameter int NUM_PENDING = 4
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int TMO = 400;

  logic      clk_i;
  logic      rst_n_i;
  axi_req_t  slv_req;
  axi_resp_t slv_resp;
  axi_req_t  mst_req;
  axi_resp_t mst_resp;
  logic      isolate;
  logic      isolated;
  logic      hold_resp;
  logic      w_alone;
  int        aw_out;
  int        ar_out;
  int        errors;
  int        n_checks;
  // Scoreboard, responses come back in issue order
  logic [ID_W-1:0]   exp_b_q[$];
  r_chan_t           exp_r_q[$];
  logic [DATA_W-1:0] exp_mem [logic [ADDR_W-1:0]];

  axi_isolate #(.NumPending(NUM_PENDING)) u_axi_isolate (
    .clk_i, .rst_n_i,
    .slv_req_i (slv_req), .slv_resp_o (slv_resp),
    .mst_req_o (mst_req), .mst_resp_i (mst_resp),
    .isolate_i (isolate), .isolated_o (isolated)
  );

  axi_iso_slave_model u_mem (
    .clk_i, .rst_n_i, .hold_resp_i (hold_resp), .req_i (mst_req), .resp_o (mst_resp)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  task automatic note_failure(input string msg);
    errors++;
    $display("%s", msg);
  endtask

  task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
    n_checks++;
    assert (got === exp) else begin
      errors++;
      $display("mismatch %s: got %h expected %h", name, got, exp);
    end
  endtask

  //////////////////////////////
  // Channel drivers
  //////////////////////////////
  task automatic issue_aw(input aw_chan_t aw);
    int t;
    slv_req.aw       = aw;
    slv_req.aw_valid = 1'b1;
    for (t = 0; t < TMO; t++) begin
      @(negedge clk_i);
      if (slv_resp.aw_ready) break;
    end
    if (t == TMO) note_failure("timeout waiting for AW ready");
    @(posedge clk_i);
    #1;
    slv_req.aw_valid = 1'b0;
    slv_req.aw       = '0;
  endtask

  task automatic stream_w(input logic [DATA_W-1:0] data);
    int t;
    slv_req.w       = '{data: data, strb: '1, last: 1'b1};
    slv_req.w_valid = 1'b1;
    for (t = 0; t < TMO; t++) begin
      @(negedge clk_i);
      if (slv_resp.w_ready) break;
    end
    if (t == TMO) note_failure("timeout waiting for W ready");
    @(posedge clk_i);
    #1;
    slv_req.w_valid = 1'b0;
    slv_req.w       = '0;
  endtask

  task automatic issue_ar(input ar_chan_t ar);
    int t;
    slv_req.ar       = ar;
    slv_req.ar_valid = 1'b1;
    for (t = 0; t < TMO; t++) begin
      @(negedge clk_i);
      if (slv_resp.ar_ready) break;
    end
    if (t == TMO) note_failure("timeout waiting for AR ready");
    @(posedge clk_i);
    #1;
    slv_req.ar_valid = 1'b0;
    slv_req.ar       = '0;
  endtask

  // Single-beat write, optionally with W offered a few cycles ahead of AW
  task automatic write_txn(input logic [ID_W-1:0] id, input logic [ADDR_W-1:0] addr,
                           input logic [DATA_W-1:0] data, input bit w_first);
    exp_b_q.push_back(id);
    exp_mem[addr] = data;
    fork
      begin
        if (w_first) begin
          w_alone = 1'b1;
          repeat (3) @(posedge clk_i);
          #1;
          w_alone = 1'b0;
        end
        issue_aw('{id: id, addr: addr, len: '0, size: 3'd2});
      end
      stream_w(data);
    join
  endtask

  task automatic read_txn(input logic [ID_W-1:0] id, input logic [ADDR_W-1:0] addr);
    exp_r_q.push_back('{id: id, data: exp_mem[addr], resp: RESP_OKAY, last: 1'b1});
    issue_ar('{id: id, addr: addr, len: '0});
  endtask

  //////////////////////////////
  // Waits
  //////////////////////////////
  task automatic wait_idle();
    int t;
    for (t = 0; t < TMO; t++) begin
      @(negedge clk_i);
      if (exp_b_q.size() == 0 && exp_r_q.size() == 0) break;
    end
    if (t == TMO) note_failure("timeout waiting for open responses to arrive");
    @(posedge clk_i);
    #1;
  endtask

  task automatic wait_isolated(input logic level);
    int t;
    for (t = 0; t < TMO; t++) begin
      @(negedge clk_i);
      if (isolated === level) break;
    end
    if (t == TMO) note_failure("timeout waiting for isolated_o to change");
    @(posedge clk_i);
    #1;
  endtask

  // Responses seen on the upstream port
  always @(posedge clk_i) begin
    r_chan_t e;
    if (rst_n_i && slv_resp.b_valid && slv_req.b_ready) begin
      if (exp_b_q.size() == 0) begin
        note_failure("B response without an open write");
      end else begin
        check_eq("slv_resp_o.b.id", 64'(slv_resp.b.id), 64'(exp_b_q.pop_front()));
        check_eq("slv_resp_o.b.resp", 64'(slv_resp.b.resp), 64'(RESP_OKAY));
      end
    end
    if (rst_n_i && slv_resp.r_valid && slv_req.r_ready) begin
      if (exp_r_q.size() == 0) begin
        note_failure("R response without an open read");
      end else begin
        e = exp_r_q.pop_front();
        check_eq("slv_resp_o.r.id", 64'(slv_resp.r.id), 64'(e.id));
        check_eq("slv_resp_o.r.data", 64'(slv_resp.r.data), 64'(e.data));
        check_eq("slv_resp_o.r.resp", 64'(slv_resp.r.resp), 64'(e.resp));
        check_eq("slv_resp_o.r.last", 64'(slv_resp.r.last), 64'(e.last));
      end
    end
  end

  // Open transactions counted at the downstream port
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      aw_out <= 0;
      ar_out <= 0;
    end else begin
      aw_out <= aw_out + int'(mst_req.aw_valid && mst_resp.aw_ready)
                       - int'(mst_resp.b_valid && mst_req.b_ready);
      ar_out <= ar_out + int'(mst_req.ar_valid && mst_resp.ar_ready)
                       - int'(mst_resp.r_valid && mst_req.r_ready && mst_resp.r.last);
    end
  end

  //////////////////////////////
  // Assertions
  //////////////////////////////
  a_quiet: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    isolated |-> (mst_req == '0))
    else begin
      errors++;
      $display("mismatch mst_req_o: got %h expected 0", $sampled(mst_req));
    end
  // Whatever address goes downstream is the one offered upstream
  a_aw_pass: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mst_req.aw_valid |-> (mst_req.aw == slv_req.aw))
    else begin
      errors++;
      $display("mismatch mst_req_o.aw: got %h expected %h", $sampled(mst_req.aw),
               $sampled(slv_req.aw));
    end
  a_stall: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    isolated |-> !(slv_resp.aw_ready || slv_resp.ar_ready))
    else note_failure("address ready raised while isolated");
  // Only an address already pending may still transfer
  a_no_aw: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ($past(isolate) && !$past(mst_req.aw_valid && !mst_resp.aw_ready))
      |-> !(mst_req.aw_valid && mst_resp.aw_ready))
    else note_failure("new AW transfer while isolation requested");
  a_no_ar: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ($past(isolate) && !$past(mst_req.ar_valid && !mst_resp.ar_ready))
      |-> !(mst_req.ar_valid && mst_resp.ar_ready))
    else note_failure("new AR transfer while isolation requested");
  a_drained: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    isolated |-> (aw_out == 0 && ar_out == 0))
    else note_failure("isolated_o high with transactions still open");
  a_limit: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    aw_out <= NUM_PENDING && ar_out <= NUM_PENDING)
    else note_failure("more open transactions than the limit");
  a_aw_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (aw_out == NUM_PENDING) |-> !slv_resp.aw_ready)
    else note_failure("AW accepted with the write count full");
  a_ar_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (ar_out == NUM_PENDING) |-> !slv_resp.ar_ready)
    else note_failure("AR accepted with the read count full");
  a_w_gate: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    w_alone |-> !mst_req.w_valid)
    else note_failure("W beat passed downstream with no AW issued");

  //////////////////////////////
  // Stimulus
  //////////////////////////////
  initial begin
    int t;
    slv_req   = '0;
    isolate   = 1'b1;
    hold_resp = 1'b0;
    w_alone   = 1'b0;
    errors    = 0;
    n_checks  = 0;
    rst_n_i   = 1'b0;
    repeat (2) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;
    slv_req.b_ready = 1'b1;
    slv_req.r_ready = 1'b1;
    check_eq("isolated_o", 64'(isolated), 64'd1);
    @(posedge clk_i);
    #1;
    isolate = 1'b0;
    @(posedge clk_i);
    #1;
    check_eq("isolated_o", 64'(isolated), 64'd0);

    // Plain traffic, first write offers W ahead of its AW
    for (int i = 0; i < 4; i++) begin
      write_txn(ID_W'(i), 32'h100 + 4 * i, 32'ha000_0000 ^ (32'h1111 * i), i == 0);
    end
    wait_idle();
    for (int i = 0; i < 4; i++) read_txn(ID_W'(i), 32'h100 + 4 * i);
    wait_idle();

    // Fill both counters with responses held, then isolate
    hold_resp = 1'b1;
    fork
      for (int i = 0; i < 6; i++) write_txn(ID_W'(i), 32'h200 + 4 * i, 32'h5c00_0000 + i, 1'b0);
      for (int i = 0; i < 6; i++) read_txn(ID_W'(i + 8), 32'h100 + 4 * (i % 4));
      begin
        for (t = 0; t < TMO; t++) begin
          @(negedge clk_i);
          if (aw_out == NUM_PENDING && ar_out == NUM_PENDING) break;
        end
        if (t == TMO) note_failure("timeout waiting for both counters to fill");
        @(posedge clk_i);
        #1;
        isolate = 1'b1;
        repeat (12) @(posedge clk_i);
        #1;
        hold_resp = 1'b0;
        wait_isolated(1'b1);
        repeat (8) @(posedge clk_i);
        #1;
        isolate = 1'b0;
        wait_isolated(1'b0);
      end
    join
    wait_idle();

    // Writes stalled during isolation must have landed
    for (int i = 0; i < 6; i++) read_txn(ID_W'(i), 32'h200 + 4 * i);
    wait_idle();

    $display("checks %0d errors %0d", n_checks, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// ==== test/axi_iso_slave_model.sv ====
// Behavioral AXI memory slave with LFSR-driven ready and valid delays and a response hold
module axi_iso_slave_model import axi_iso_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  logic      hold_resp_i,
  input  axi_req_t  req_i,
  output axi_resp_t resp_o
);
  timeunit 1ns;
  timeprecision 1ps;

  logic [31:0]       lfsr;
  logic [DATA_W-1:0] mem [logic [ADDR_W-1:0]];
  aw_chan_t          aw_q[$];
  ar_chan_t          ar_q[$];
  b_chan_t           b_q[$];
  logic [LEN_W-1:0]  w_beat;
  logic [LEN_W-1:0]  r_beat;

  // Galois form, taps 32,22,2,1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {1'b0, s[31:1]} ^ (s[0] ? 32'h8020_0003 : 32'h0);
  endfunction

  // Unwritten words read back a pattern of their full address
  function automatic logic [DATA_W-1:0] mem_read(input logic [ADDR_W-1:0] a);
    if (mem.exists(a)) begin
      return mem[a];
    end
    return a ^ 32'hc3a5_5a3c;
  endfunction

  always @(posedge clk_i) begin
    axi_resp_t         nxt;
    logic [ADDR_W-1:0] a;
    if (!rst_n_i) begin
      lfsr = 32'h4d57;
      aw_q.delete();
      ar_q.delete();
      b_q.delete();
      w_beat = '0;
      r_beat = '0;
      resp_o <= '0;
    end else begin
      nxt = resp_o;
      if (req_i.aw_valid && resp_o.aw_ready) begin
        aw_q.push_back(req_i.aw);
      end
      if (req_i.ar_valid && resp_o.ar_ready) begin
        ar_q.push_back(req_i.ar);
      end
      // W ready is only raised with an address waiting
      if (req_i.w_valid && resp_o.w_ready) begin
        a = aw_q[0].addr + ADDR_W'(w_beat) * 4;
        mem[a] = mem_read(a);
        for (int i = 0; i < STRB_W; i++) begin
          if (req_i.w.strb[i]) mem[a][8*i +: 8] = req_i.w.data[8*i +: 8];
        end
        if (req_i.w.last) begin
          b_q.push_back({aw_q[0].id, RESP_OKAY});
          void'(aw_q.pop_front());
          w_beat = '0;
        end else begin
          w_beat = w_beat + LEN_W'(1);
        end
      end
      // B
      if (nxt.b_valid && req_i.b_ready) nxt.b_valid = 1'b0;
      if (!nxt.b_valid && !hold_resp_i && b_q.size() > 0) begin
        lfsr = lfsr_step(lfsr);
        if (lfsr[0]) begin
          nxt.b       = b_q.pop_front();
          nxt.b_valid = 1'b1;
        end
      end
      // R, one beat at a time from the oldest burst
      if (nxt.r_valid && req_i.r_ready) begin
        nxt.r_valid = 1'b0;
        if (nxt.r.last) begin
          void'(ar_q.pop_front());
          r_beat = '0;
        end else begin
          r_beat = r_beat + LEN_W'(1);
        end
      end
      if (!nxt.r_valid && !hold_resp_i && ar_q.size() > 0) begin
        lfsr = lfsr_step(lfsr);
        if (lfsr[0]) begin
          nxt.r.id    = ar_q[0].id;
          nxt.r.data  = mem_read(ar_q[0].addr + ADDR_W'(r_beat) * 4);
          nxt.r.resp  = RESP_OKAY;
          nxt.r.last  = (r_beat == ar_q[0].len);
          nxt.r_valid = 1'b1;
        end
      end
      // Random ready per cycle
      lfsr = lfsr_step(lfsr);
      nxt.aw_ready = lfsr[0];
      lfsr = lfsr_step(lfsr);
      nxt.w_ready = lfsr[0] && (aw_q.size() > 0);
      lfsr = lfsr_step(lfsr);
      nxt.ar_ready = lfsr[0];
      resp_o <= nxt;
    end
  end

endmodule

// ==== verilog/axi_isolate.sv ====
// AXI isolator top level with write and read controllers and their data paths
module axi_isolate import axi_iso_pkg::*; #(
  parameter int unsigned NumPending = 4
) (
  input  logic      clk_i,
  input  logic      rst_n_i,
  // Upstream port
  input  axi_req_t  slv_req_i,
  output axi_resp_t slv_resp_o,
  // Downstream port
  output axi_req_t  mst_req_o,
  input  axi_resp_t mst_resp_i,
  // Level request/acknowledge pair
  input  logic      isolate_i,
  output logic      isolated_o
);

  // Master side outputs
  aw_chan_t mst_aw;
  ar_chan_t mst_ar;
  w_chan_t  mst_w;
  logic     mst_aw_valid, mst_ar_valid, mst_w_valid;
  logic     mst_b_ready, mst_r_ready;
  // Slave side outputs
  b_chan_t  slv_b;
  r_chan_t  slv_r;
  logic     slv_aw_ready, slv_ar_ready, slv_w_ready;
  logic     slv_b_valid, slv_r_valid;
  // Controller and path handshakes
  logic     aw_issue, aw_cut, aw_iso, aw_full, aw_empty;
  logic     ar_issue, ar_cut, ar_iso, ar_full, ar_empty;

  //////////////////////////////
  // Write direction
  //////////////////////////////
  axi_iso_chan_ctrl #(.addr_chan_t(aw_chan_t)) u_aw_ctrl (
    .clk_i, .rst_n_i, .isolate_i,
    .slv_addr_i   (slv_req_i.aw),
    .slv_valid_i  (slv_req_i.aw_valid),
    .slv_ready_o  (slv_aw_ready),
    .mst_addr_o   (mst_aw),
    .mst_valid_o  (mst_aw_valid),
    .mst_ready_i  (mst_resp_i.aw_ready),
    .full_i       (aw_full),
    .empty_i      (aw_empty),
    .addr_issue_o (aw_issue),
    .resp_cut_o   (aw_cut),
    .iso_o        (aw_iso)
  );

  axi_iso_wr_path #(.NumPending(NumPending)) u_wr_path (
    .clk_i, .rst_n_i,
    .aw_issue_i (aw_issue), .resp_cut_i (aw_cut),
    .slv_w_i (slv_req_i.w), .slv_w_valid_i (slv_req_i.w_valid), .slv_w_ready_o (slv_w_ready),
    .mst_w_o (mst_w), .mst_w_valid_o (mst_w_valid), .mst_w_ready_i (mst_resp_i.w_ready),
    .mst_b_i (mst_resp_i.b), .mst_b_valid_i (mst_resp_i.b_valid), .mst_b_ready_o (mst_b_ready),
    .slv_b_o (slv_b), .slv_b_valid_o (slv_b_valid), .slv_b_ready_i (slv_req_i.b_ready),
    .aw_full_o (aw_full), .aw_empty_o (aw_empty)
  );

  //////////////////////////////
  // Read direction
  //////////////////////////////
  axi_iso_chan_ctrl #(.addr_chan_t(ar_chan_t)) u_ar_ctrl (
    .clk_i, .rst_n_i, .isolate_i,
    .slv_addr_i   (slv_req_i.ar),
    .slv_valid_i  (slv_req_i.ar_valid),
    .slv_ready_o  (slv_ar_ready),
    .mst_addr_o   (mst_ar),
    .mst_valid_o  (mst_ar_valid),
    .mst_ready_i  (mst_resp_i.ar_ready),
    .full_i       (ar_full),
    .empty_i      (ar_empty),
    .addr_issue_o (ar_issue),
    .resp_cut_o   (ar_cut),
    .iso_o        (ar_iso)
  );

  axi_iso_rd_path #(.NumPending(NumPending)) u_rd_path (
    .clk_i, .rst_n_i,
    .ar_issue_i (ar_issue), .resp_cut_i (ar_cut),
    .mst_r_i (mst_resp_i.r), .mst_r_valid_i (mst_resp_i.r_valid), .mst_r_ready_o (mst_r_ready),
    .slv_r_o (slv_r), .slv_r_valid_o (slv_r_valid), .slv_r_ready_i (slv_req_i.r_ready),
    .ar_full_o (ar_full), .ar_empty_o (ar_empty)
  );

  // Repack both bundles
  always_comb begin
    mst_req_o.aw        = mst_aw;
    mst_req_o.aw_valid  = mst_aw_valid;
    mst_req_o.w         = mst_w;
    mst_req_o.w_valid   = mst_w_valid;
    mst_req_o.b_ready   = mst_b_ready;
    mst_req_o.ar        = mst_ar;
    mst_req_o.ar_valid  = mst_ar_valid;
    mst_req_o.r_ready   = mst_r_ready;
    slv_resp_o.aw_ready = slv_aw_ready;
    slv_resp_o.w_ready  = slv_w_ready;
    slv_resp_o.b        = slv_b;
    slv_resp_o.b_valid  = slv_b_valid;
    slv_resp_o.ar_ready = slv_ar_ready;
    slv_resp_o.r        = slv_r;
    slv_resp_o.r_valid  = slv_r_valid;
  end

  // Granted only when both directions are quiet
  assign isolated_o = aw_iso && ar_iso;

endmodule

// ==== verilog/axi_iso_rd_path.sv ====
// Read path with AR counter and R channel gating, counter closed on the last R beat
module axi_iso_rd_path import axi_iso_pkg::*; #(
  parameter int unsigned NumPending = 4
) (
  input  logic    clk_i,
  input  logic    rst_n_i,
  input  logic    ar_issue_i,
  input  logic    resp_cut_i,
  // R channel
  input  r_chan_t mst_r_i,
  input  logic    mst_r_valid_i,
  output logic    mst_r_ready_o,
  output r_chan_t slv_r_o,
  output logic    slv_r_valid_o,
  input  logic    slv_r_ready_i,
  // AR counter state
  output logic    ar_full_o,
  output logic    ar_empty_o
);

  logic r_last_fire;

  // Open reads, one per burst
  axi_iso_pending_cnt #(.NumPending(NumPending)) u_ar_cnt (
    .clk_i,
    .rst_n_i,
    .inc_i   (ar_issue_i),
    .dec_i   (r_last_fire),
    .full_o  (ar_full_o),
    .empty_o (ar_empty_o)
  );

  // R is cut only while fully isolated
  assign slv_r_o       = resp_cut_i ? r_chan_t'('0) : mst_r_i;
  assign slv_r_valid_o = !resp_cut_i && mst_r_valid_i;
  assign mst_r_ready_o = !resp_cut_i && slv_r_ready_i;

  // Only the final beat closes a burst
  assign r_last_fire   = mst_r_valid_i && mst_r_ready_o && mst_r_i.last;

endmodule

// ==== verilog/axi_iso_wr_path.sv ====
// Write path with AW and W counters, W channel gating and B channel gating
module axi_iso_wr_path import axi_iso_pkg::*; #(
  parameter int unsigned NumPending = 4
) (
  input  logic    clk_i,
  input  logic    rst_n_i,
  input  logic    aw_issue_i,
  input  logic    resp_cut_i,
  // W channel
  input  w_chan_t slv_w_i,
  input  logic    slv_w_valid_i,
  output logic    slv_w_ready_o,
  output w_chan_t mst_w_o,
  output logic    mst_w_valid_o,
  input  logic    mst_w_ready_i,
  // B channel
  input  b_chan_t mst_b_i,
  input  logic    mst_b_valid_i,
  output logic    mst_b_ready_o,
  output b_chan_t slv_b_o,
  output logic    slv_b_valid_o,
  input  logic    slv_b_ready_i,
  // AW counter state
  output logic    aw_full_o,
  output logic    aw_empty_o
);

  logic w_empty;
  logic w_connect;
  logic w_last_fire;
  logic b_fire;

  // Open writes, closed by the B response
  axi_iso_pending_cnt #(.NumPending(NumPending)) u_aw_cnt (
    .clk_i,
    .rst_n_i,
    .inc_i   (aw_issue_i),
    .dec_i   (b_fire),
    .full_o  (aw_full_o),
    .empty_o (aw_empty_o)
  );

  // Bursts still owed data, closed by the last W beat
  // Cannot run ahead of the AW count, so its full flag stays open
  axi_iso_pending_cnt #(.NumPending(NumPending)) u_w_cnt (
    .clk_i,
    .rst_n_i,
    .inc_i   (aw_issue_i),
    .dec_i   (w_last_fire),
    .full_o  (),
    .empty_o (w_empty)
  );

  // W only flows once an AW has been issued, this cycle or before
  assign w_connect     = !w_empty || aw_issue_i;
  assign mst_w_o       = w_connect ? slv_w_i : w_chan_t'('0);
  assign mst_w_valid_o = w_connect && slv_w_valid_i;
  assign slv_w_ready_o = w_connect && mst_w_ready_i;
  assign w_last_fire   = mst_w_valid_o && mst_w_ready_i && mst_w_o.last;

  // B is cut only while fully isolated
  assign slv_b_o       = resp_cut_i ? b_chan_t'('0) : mst_b_i;
  assign slv_b_valid_o = !resp_cut_i && mst_b_valid_i;
  assign mst_b_ready_o = !resp_cut_i && slv_b_ready_i;
  assign b_fire        = mst_b_valid_i && mst_b_ready_o;

endmodule

// ==== verilog/axi_iso_chan_ctrl.sv ====
// Isolation FSM for one direction with gating of that direction's address channel
module axi_iso_chan_ctrl import axi_iso_pkg::*; #(
  // AW or AR payload
  parameter type addr_chan_t = aw_chan_t
) (
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  logic       isolate_i,
  // Upstream address channel
  input  addr_chan_t slv_addr_i,
  input  logic       slv_valid_i,
  output logic       slv_ready_o,
  // Downstream address channel
  output addr_chan_t mst_addr_o,
  output logic       mst_valid_o,
  input  logic       mst_ready_i,
  // Counter state from the path
  input  logic       full_i,
  input  logic       empty_i,
  // Status towards the path and the top level
  output logic       addr_issue_o,
  output logic       resp_cut_o,
  output logic       iso_o
);

  iso_state_e state_q;
  iso_state_e state_d;

  //////////////////////////////
  // Next state and gating
  //////////////////////////////
  always_comb begin
    state_d     = state_q;
    // Straight through unless a state says otherwise
    mst_addr_o  = slv_addr_i;
    mst_valid_o = slv_valid_i;
    slv_ready_o = mst_ready_i;
    unique case (state_q)
      NORMAL: begin
        if (full_i) begin
          // No room for another open transaction
          mst_valid_o = 1'b0;
          slv_ready_o = 1'b0;
          if (isolate_i) begin
            state_d = DRAIN;
          end
        end else if (slv_valid_i && !mst_ready_i) begin
          // Offered but not taken, the valid must stay up
          state_d = HOLD;
        end else if (isolate_i) begin
          state_d = DRAIN;
        end
      end
      HOLD: begin
        // Payload is stable since upstream valid is held too
        mst_valid_o = 1'b1;
        if (mst_ready_i) begin
          state_d = isolate_i ? DRAIN : NORMAL;
        end
      end
      DRAIN: begin
        // No new addresses, wait for open ones to finish
        mst_addr_o  = '0;
        mst_valid_o = 1'b0;
        slv_ready_o = 1'b0;
        if (empty_i) begin
          state_d = ISOLATE;
        end
      end
      ISOLATE: begin
        mst_addr_o  = '0;
        mst_valid_o = 1'b0;
        slv_ready_o = 1'b0;
        // Release on the level of isolate_i
        if (!isolate_i) begin
          state_d = NORMAL;
        end
      end
      default: begin
        state_d = ISOLATE;
      end
    endcase
  end

  // Comes out of reset isolated
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= ISOLATE;
    end else begin
      state_q <= state_d;
    end
  end

  //////////////////////////////
  // Status
  //////////////////////////////
  // Counted once, when first offered downstream; HOLD does not count again
  assign addr_issue_o = (state_q == NORMAL) && mst_valid_o;
  assign resp_cut_o   = (state_q == ISOLATE);
  assign iso_o        = (state_q == ISOLATE);

endmodule

// ==== verilog/axi_iso_pending_cnt.sv ====
// Up/down counter of open transactions with full and empty flags
module axi_iso_pending_cnt #(
  // Most transactions that may be open at once
  parameter int unsigned NumPending = 4
) (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic inc_i,
  input  logic dec_i,
  output logic full_o,
  output logic empty_o
);

  // Room for 0 up to NumPending
  localparam int unsigned CntW = $clog2(NumPending + 1);

  logic [CntW-1:0] cnt_q;
  logic [CntW-1:0] cnt_d;

  // Both at once cancel out
  always_comb begin
    cnt_d = cnt_q;
    if (inc_i && !dec_i) begin
      cnt_d = cnt_q + CntW'(1);
    end else if (dec_i && !inc_i) begin
      cnt_d = cnt_q - CntW'(1);
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_d;
    end
  end

  // Flags come straight from the register
  assign full_o  = (cnt_q == CntW'(NumPending));
  assign empty_o = (cnt_q == '0);

endmodule

// ==== verilog/axi_iso_pkg.sv ====
// Bus widths, AXI channel structs, request/response bundles and isolation state encoding
package axi_iso_pkg;

  // Bus widths
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;
  localparam int unsigned ID_W   = 4;
  localparam int unsigned LEN_W  = 8;
  localparam int unsigned STRB_W = DATA_W / 8;
  localparam int unsigned RESP_W = 2;

  localparam logic [RESP_W-1:0] RESP_OKAY = 2'b00;

  // Address channels, AR carries no size field here
  typedef struct packed {
    logic [ID_W-1:0]   id;
    logic [ADDR_W-1:0] addr;
    logic [LEN_W-1:0]  len;
    logic [2:0]        size;
  } aw_chan_t;

  typedef struct packed {
    logic [ID_W-1:0]   id;
    logic [ADDR_W-1:0] addr;
    logic [LEN_W-1:0]  len;
  } ar_chan_t;

  // Data and response channels
  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [STRB_W-1:0] strb;
    logic              last;
  } w_chan_t;

  typedef struct packed {
    logic [ID_W-1:0]   id;
    logic [RESP_W-1:0] resp;
  } b_chan_t;

  typedef struct packed {
    logic [ID_W-1:0]   id;
    logic [DATA_W-1:0] data;
    logic [RESP_W-1:0] resp;
    logic              last;
  } r_chan_t;

  // Everything a master drives
  typedef struct packed {
    aw_chan_t aw;
    logic     aw_valid;
    w_chan_t  w;
    logic     w_valid;
    logic     b_ready;
    ar_chan_t ar;
    logic     ar_valid;
    logic     r_ready;
  } axi_req_t;

  // Everything a slave drives
  typedef struct packed {
    logic     aw_ready;
    logic     w_ready;
    b_chan_t  b;
    logic     b_valid;
    logic     ar_ready;
    r_chan_t  r;
    logic     r_valid;
  } axi_resp_t;

  // Per-direction isolation FSM
  typedef enum logic [1:0] {
    NORMAL,
    HOLD,
    DRAIN,
    ISOLATE
  } iso_state_e;

endpackage
